//--- sens_io_pkg.sv
////////////////////
// sensor i/o core shared definitions:
// block addresses, control and status word layouts,
// command word union and status payload
////////////////////
package sens_io_pkg;

    // block decode
    localparam logic [15:0] sensio_addr_c      = 16'h0330; // base of the register block
    localparam logic [15:0] sensio_addr_mask_c = 16'h07f8; // low 3 bits select local reg
    localparam logic [2:0]  sensio_ctrl_c      = 3'd0;     // control register
    localparam logic [2:0]  sensio_status_c    = 3'd1;     // status mode register

    localparam logic [7:0]  status_reg_addr_c  = 8'h21;    // first byte of a status packet
    localparam int          cmd_bytes_c        = 6;        // al, ah, d0..d3

    // general purpose pin mode
    typedef enum logic [1:0] {
        gp_float   = 2'd0, // output disabled
        gp_low     = 2'd1,
        gp_high    = 2'd2,
        gp_trigger = 2'd3  // drives high as well
    } gp_mode_e;

    typedef struct packed {
        logic     en;   // update this pin
        gp_mode_e mode;
    } gp_field_t;

    // control register write, bit positions as in the sensor board firmware
    typedef struct packed {
        logic [7:0]      rsvd_hi;  // 31:24
        gp_field_t [3:0] gp;       // 23:12, gp0 at 14:12
        logic [3:0]      rsvd_mid; // 11:8
        logic            pll_en;   // 7
        logic            pll_rst;  // 6, sensor pll reset level
        logic [3:0]      rsvd_lo;  // 5:2
        logic            mrst_en;  // 1
        logic            mrst;     // 0, 0 holds sensor in reset
    } sens_ctrl_t;

    // status mode write
    typedef struct packed {
        logic [23:0] rsvd;
        logic [1:0]  mode; // 0 off, 1 single, 2/3 auto
        logic [5:0]  seq;  // echoed in every packet
    } status_cmd_t;

    // one data word, meaning depends on the local register address
    typedef union packed {
        sens_ctrl_t  ctrl;
        status_cmd_t stat;
    } cmd_word_u;

    typedef struct packed {
        logic       we;   // single cycle write strobe
        logic [2:0] addr; // local register
        cmd_word_u  data;
    } cmd_t;

    // status payload, 10 bits
    typedef struct packed {
        logic       senspgm;         // 9, sensor board present
        logic       sns_mrst;        // 8
        logic       rst_pll;         // 7
        logic       prsts;           // 6
        logic       perr_persistent; // 5
        logic       hact_alive;      // 4
        logic [3:0] gp_di;           // 3:0
    } sens_status_t;

endpackage

//--- cmd_deser.sv
////////////////////
// byte-serial command receiver:
// six byte collection and block address match
////////////////////
`timescale 1ns/1ps

module cmd_deser import sens_io_pkg::*; #(
    parameter logic [15:0] ADDR      = sensio_addr_c,
    parameter logic [15:0] ADDR_MASK = sensio_addr_mask_c
) (
    input  logic       pclk,
    input  logic       async_prst_with_sens_mrst,
    input  logic [7:0] cmd_ad_i,  // al, ah, d0, d1, d2, d3
    input  logic       cmd_stb_i, // with byte 0 only
    output cmd_t       cmd_o
);

    localparam int         sr_bits_c = 8 * cmd_bytes_c;
    localparam logic [2:0] last_c    = 3'(cmd_bytes_c - 1);

    logic [2:0]           cnt_q;   // bytes taken, 0 when idle
    logic                 full_q;  // all bytes in sr_q
    logic [sr_bits_c-1:0] sr_q;    // byte 0 ends up in the low byte
    logic                 addr_hit;
    logic                 we_q;
    logic [2:0]           addr_q;
    logic [31:0]          data_q;

    // only the masked bits have to match the base
    assign addr_hit = ((sr_q[15:0] ^ ADDR) & ADDR_MASK) == 16'h0000;

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            cnt_q  <= 3'd0;
            full_q <= 1'b0;
        end else begin
            full_q <= 1'b0;
            if (cmd_stb_i) begin
                cnt_q <= 3'd1;   // restart on every strobe
            end else if (cnt_q == last_c) begin
                cnt_q  <= 3'd0;  // last data byte taken
                full_q <= 1'b1;
            end else if (cnt_q != 3'd0) begin
                cnt_q <= cnt_q + 3'd1;
            end
        end
    end

    // shift in lsb first
    always_ff @(posedge pclk) begin
        if (cmd_stb_i || (cnt_q != 3'd0)) begin
            sr_q <= {cmd_ad_i, sr_q[sr_bits_c-1:8]};
        end
    end

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            we_q <= 1'b0;
        end else begin
            we_q <= full_q && addr_hit; // one cycle, ours only
        end
    end

    always_ff @(posedge pclk) begin
        if (full_q) begin
            addr_q <= sr_q[2:0];   // local register
            data_q <= sr_q[47:16]; // d3..d0
        end
    end

    assign cmd_o = {we_q, addr_q, data_q};

endmodule

//--- sens_ctrl_regs.sv
////////////////////
// sensor control register and status mode register,
// each control field with its own enable bit
////////////////////
`timescale 1ns/1ps

module sens_ctrl_regs import sens_io_pkg::*; (
    input  logic        pclk,
    input  logic        async_prst_with_sens_mrst,
    input  cmd_t        cmd_i,
    output logic        sns_mrst_o,       // active low at the sensor
    output logic        rst_pll_o,        // sensor pll reset level
    output logic [3:0]  gp_oe_o,
    output logic [3:0]  gp_do_o,
    output logic        set_ctrl_o,       // pulse on each control write
    output logic        status_mode_wr_o, // pulse on each status write
    output status_cmd_t status_cmd_o
);

    logic       wr_ctrl;
    logic       wr_stat;
    gp_mode_e   gp_q [4];  // per pin mode
    logic [1:0] mode_q;
    logic [5:0] seq_q;

    assign wr_ctrl = cmd_i.we && (cmd_i.addr == sensio_ctrl_c);
    assign wr_stat = cmd_i.we && (cmd_i.addr == sensio_status_c);

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            set_ctrl_o       <= 1'b0;
            status_mode_wr_o <= 1'b0;
            sns_mrst_o       <= 1'b0;   // sensor held in reset
            rst_pll_o        <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                gp_q[i] <= gp_float;
            end
        end else begin
            set_ctrl_o       <= wr_ctrl;
            status_mode_wr_o <= wr_stat;
            if (wr_ctrl && cmd_i.data.ctrl.mrst_en) begin
                sns_mrst_o <= cmd_i.data.ctrl.mrst;
            end
            if (wr_ctrl && cmd_i.data.ctrl.pll_en) begin
                rst_pll_o <= cmd_i.data.ctrl.pll_rst;
            end
            for (int i = 0; i < 4; i++) begin
                if (wr_ctrl && cmd_i.data.ctrl.gp[i].en) begin
                    gp_q[i] <= cmd_i.data.ctrl.gp[i].mode;
                end
            end
        end
    end

    // status register, same word seen as status_cmd_t
    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            mode_q <= 2'd0; // off
            seq_q  <= 6'd0;
        end else if (wr_stat) begin
            mode_q <= cmd_i.data.stat.mode;
            seq_q  <= cmd_i.data.stat.seq;
        end
    end

    assign status_cmd_o = '{rsvd: 24'h0, mode: mode_q, seq: seq_q};

    // pad control from pin modes
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            gp_oe_o[i] = (gp_q[i] != gp_float); // low, high, trigger drive
            gp_do_o[i] = gp_q[i][1];            // high and trigger drive 1
        end
    end

endmodule

//--- sens_io_monitor.sv
////////////////////
// line activity flag, sticky parity error flag,
// pixel side reset stretcher
////////////////////
`timescale 1ns/1ps

module sens_io_monitor (
    input  logic pclk,
    input  logic async_prst_with_sens_mrst,
    input  logic prst_i,            // pixel side reset request
    input  logic dvalid_i,          // pixel data valid level
    input  logic perr_i,            // parity error pulse
    input  logic set_ctrl_i,        // clears both flags
    input  logic sns_mrst_i,        // low while sensor is in reset
    input  logic rst_pll_i,
    output logic hact_alive_o,
    output logic perr_persistent_o,
    output logic prsts_o            // prst including sensor resets
);

    logic       dvalid_q;   // for edge detect
    logic       hold_rst;   // programmed reset sources
    logic [1:0] prst_q;     // stretcher, shifts toward bit 0

    assign hold_rst = prst_i || !sns_mrst_i || rst_pll_i;
    assign prsts_o  = prst_q[0];

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            dvalid_q          <= 1'b0;
            hact_alive_o      <= 1'b0;
            perr_persistent_o <= 1'b0;
        end else begin
            dvalid_q <= dvalid_i;
            if (set_ctrl_i) begin
                hact_alive_o <= 1'b0;           // clear has priority
            end else if (dvalid_i && !dvalid_q) begin
                hact_alive_o <= 1'b1;           // line started
            end
            if (set_ctrl_i) begin
                perr_persistent_o <= 1'b0;
            end else if (perr_i) begin
                perr_persistent_o <= 1'b1;
            end
        end
    end

    // falls two cycles after the last source drops
    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            prst_q <= 2'b11;
        end else if (hold_rst) begin
            prst_q <= 2'b11;
        end else begin
            prst_q <= {1'b0, prst_q[1]};
        end
    end

endmodule

//--- status_generate.sv
////////////////////
// status request logic (single and auto modes)
// and byte packet sender
////////////////////
`timescale 1ns/1ps

module status_generate import sens_io_pkg::*; #(
    parameter logic [7:0] STATUS_ADDR  = status_reg_addr_c,
    parameter int         PAYLOAD_BITS = 10
) (
    input  logic         pclk,
    input  logic         async_prst_with_sens_mrst,
    input  logic         mode_wr_i,      // status register written
    input  status_cmd_t  status_cmd_i,
    input  sens_status_t status_i,
    input  logic         status_start_i, // host takes byte 0
    output logic [7:0]   status_ad_o,
    output logic         status_rq_o
);

    localparam int pkt_bits_c  = PAYLOAD_BITS + 6;       // seq + payload
    localparam int pkt_bytes_c = (pkt_bits_c + 7) / 8;   // bytes after the address
    localparam int pkt_w_c     = 8 * pkt_bytes_c;
    localparam int cnt_bits_c  = $clog2(pkt_bytes_c + 1);

    logic [PAYLOAD_BITS-1:0] payload;
    logic [PAYLOAD_BITS-1:0] sent_q;   // payload of the last packet
    logic [1:0]              mode_q;
    logic [5:0]              seq_q;
    logic                    rq_q;
    logic [cnt_bits_c-1:0]   left_q;   // bytes still to send
    logic [pkt_w_c-1:0]      pkt_q;    // next byte in the low bits
    logic                    start_ok;
    logic                    busy;
    logic                    auto_rq;

    assign payload  = PAYLOAD_BITS'(status_i);
    assign start_ok = status_start_i && rq_q;
    assign busy     = (left_q != '0);
    assign auto_rq  = mode_q[1] && (payload != sent_q) && !busy; // modes 2,3

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            mode_q <= 2'd0;
            seq_q  <= 6'd0;
            rq_q   <= 1'b0;
        end else begin
            if (mode_wr_i) begin
                mode_q <= status_cmd_i.mode;
                seq_q  <= status_cmd_i.seq;
            end
            if (start_ok) begin
                rq_q <= 1'b0;                           // host answered
            end else if (mode_wr_i) begin
                rq_q <= (status_cmd_i.mode != 2'd0);    // off cancels pending request
            end else if (auto_rq) begin
                rq_q <= 1'b1;                           // payload changed
            end
        end
    end

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            sent_q <= '0;
            left_q <= '0;
        end else if (start_ok) begin
            sent_q <= payload;
            left_q <= cnt_bits_c'(pkt_bytes_c);
        end else if (busy) begin
            left_q <= left_q - 1'b1;
        end
    end

    // byte 1 = {seq, payload[1:0]}, then payload[9:2]
    always_ff @(posedge pclk) begin
        if (start_ok) begin
            pkt_q <= pkt_w_c'({payload[PAYLOAD_BITS-1:2], seq_q, payload[1:0]});
        end else if (busy) begin
            pkt_q <= pkt_q >> 8;
        end
    end

    assign status_rq_o = rq_q;
    assign status_ad_o = rq_q ? STATUS_ADDR :   // byte 0 while waiting
                         busy ? pkt_q[7:0]  :
                                8'h00;

endmodule

//--- sens_io_top.sv
////////////////////
// sensor i/o core top level:
// command receiver, registers, monitor, status sender
////////////////////
`timescale 1ns/1ps

module sens_io_top import sens_io_pkg::*; #(
    parameter logic [15:0] ADDR         = sensio_addr_c,
    parameter logic [15:0] ADDR_MASK    = sensio_addr_mask_c,
    parameter logic [7:0]  STATUS_ADDR  = status_reg_addr_c,
    parameter int          PAYLOAD_BITS = $bits(sens_status_t)
) (
    input  logic       pclk,
    input  logic       async_prst_with_sens_mrst,
    input  logic       prst_i,
    input  logic [7:0] cmd_ad_i,       // al-ah-d0-d1-d2-d3
    input  logic       cmd_stb_i,      // with the first byte
    output logic [7:0] status_ad_o,    // addr - {seq, st[1:0]} - st[9:2]
    output logic       status_rq_o,
    input  logic       status_start_i,
    input  logic       dvalid_i,
    input  logic       perr_i,
    input  logic [3:0] gp_di_i,        // pin readback
    input  logic       senspgm_i,      // sensor board present
    output logic [3:0] gp_oe_o,
    output logic [3:0] gp_do_o,
    output logic       sns_mrst_o,
    output logic       prsts_o
);

    cmd_t         cmd;
    logic         rst_pll;
    logic         set_ctrl;
    logic         status_mode_wr;
    status_cmd_t  status_cmd;
    logic         hact_alive;
    logic         perr_persistent;
    sens_status_t status;

    assign status = '{
        senspgm:         senspgm_i,
        sns_mrst:        sns_mrst_o,
        rst_pll:         rst_pll,
        prsts:           prsts_o,
        perr_persistent: perr_persistent,
        hact_alive:      hact_alive,
        gp_di:           gp_di_i
    };

    cmd_deser #(
        .ADDR      (ADDR),
        .ADDR_MASK (ADDR_MASK)
    ) cmd_deser_i (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .cmd_ad_i                  (cmd_ad_i),
        .cmd_stb_i                 (cmd_stb_i),
        .cmd_o                     (cmd)
    );

    sens_ctrl_regs sens_ctrl_regs_i (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .cmd_i                     (cmd),
        .sns_mrst_o                (sns_mrst_o),
        .rst_pll_o                 (rst_pll),
        .gp_oe_o                   (gp_oe_o),
        .gp_do_o                   (gp_do_o),
        .set_ctrl_o                (set_ctrl),
        .status_mode_wr_o          (status_mode_wr),
        .status_cmd_o              (status_cmd)
    );

    sens_io_monitor sens_io_monitor_i (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .prst_i                    (prst_i),
        .dvalid_i                  (dvalid_i),
        .perr_i                    (perr_i),
        .set_ctrl_i                (set_ctrl),
        .sns_mrst_i                (sns_mrst_o),
        .rst_pll_i                 (rst_pll),
        .hact_alive_o              (hact_alive),
        .perr_persistent_o         (perr_persistent),
        .prsts_o                   (prsts_o)
    );

    status_generate #(
        .STATUS_ADDR  (STATUS_ADDR),
        .PAYLOAD_BITS (PAYLOAD_BITS)
    ) status_generate_i (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .mode_wr_i                 (status_mode_wr),
        .status_cmd_i              (status_cmd),
        .status_i                  (status),
        .status_start_i            (status_start_i),
        .status_ad_o               (status_ad_o),
        .status_rq_o               (status_rq_o)
    );

endmodule

//--- tb_sens_io.sv
////////////////////
// sensor i/o core testbench:
// clock, reset, command and status packet tasks,
// immediate assertions, watchdog, summary line
////////////////////
`timescale 1ns/1ps

module tb_sens_io;

    localparam int          half_period_c  = 20;        // 40 ns clock
    localparam int          watchdog_cyc_c = 400;
    localparam int          rq_wait_c      = 40;        // max cycles for one request
    localparam logic [15:0] ctrl_addr_c    = 16'h0330;  // control register
    localparam logic [15:0] stat_addr_c    = 16'h0331;  // status mode register
    localparam logic [15:0] far_addr_c     = 16'h0340;  // outside the block

    // model of the register levels and monitor flags
    typedef struct packed {
        logic mrst;   // 1 once sensor reset released
        logic pll;
        logic prsts;
        logic perr;
        logic hact;
    } exp_state_t;

    logic       pclk;
    logic       async_prst_with_sens_mrst;
    logic       prst_i;
    logic [7:0] cmd_ad_i;
    logic       cmd_stb_i;
    logic [7:0] status_ad_o;
    logic       status_rq_o;
    logic       status_start_i;
    logic       dvalid_i;
    logic       perr_i;
    logic [3:0] gp_di_i;
    logic       senspgm_i;
    logic [3:0] gp_oe_o;
    logic [3:0] gp_do_o;
    logic       sns_mrst_o;
    logic       prsts_o;

    int         n_checks;
    int         n_errors;
    integer     seed;
    exp_state_t exp_st;

    sens_io_top sens_io_top_i (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .prst_i                    (prst_i),
        .cmd_ad_i                  (cmd_ad_i),
        .cmd_stb_i                 (cmd_stb_i),
        .status_ad_o               (status_ad_o),
        .status_rq_o               (status_rq_o),
        .status_start_i            (status_start_i),
        .dvalid_i                  (dvalid_i),
        .perr_i                    (perr_i),
        .gp_di_i                   (gp_di_i),
        .senspgm_i                 (senspgm_i),
        .gp_oe_o                   (gp_oe_o),
        .gp_do_o                   (gp_do_o),
        .sns_mrst_o                (sns_mrst_o),
        .prsts_o                   (prsts_o)
    );

    always #half_period_c pclk = ~pclk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp_v);
        n_checks++;
        assert (got === exp_v) else begin
            n_errors++;
            $display("Mismatch %s: got 'h%0h, expected 'h%0h at %0t", name, got, exp_v, $time);
        end
    endtask

    // control word at the register bit positions, gp en above its mode
    function automatic logic [31:0] ctrl_word(input logic mrst_en, input logic mrst,
                                              input logic pll_en, input logic pll,
                                              input logic [3:0] gp_en, input logic [7:0] gp_mode);
        logic [31:0] w;
        w    = 32'h0;
        w[0] = mrst;
        w[1] = mrst_en;
        w[6] = pll;
        w[7] = pll_en;
        for (int i = 0; i < 4; i++) begin
            w[12 + 3*i +: 2] = gp_mode[2*i +: 2];
            w[14 + 3*i]      = gp_en[i];
        end
        return w;
    endfunction

    function automatic logic [31:0] status_word(input logic [1:0] mode, input logic [5:0] seq);
        return {24'h0, mode, seq};
    endfunction

    function automatic logic [9:0] expected_payload();
        return {senspgm_i, exp_st.mrst, exp_st.pll, exp_st.prsts,
                exp_st.perr, exp_st.hact, gp_di_i};
    endfunction

    // al, ah, d0..d3, returns once registers show the write
    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] bytes;
        bytes = {data, addr};
        for (int i = 0; i < 6; i++) begin
            @(negedge pclk);
            cmd_stb_i = (i == 0);          // first byte only
            cmd_ad_i  = bytes[8*i +: 8];
        end
        @(negedge pclk);
        cmd_stb_i = 1'b0;
        cmd_ad_i  = 8'h00;
        repeat (2) @(negedge pclk);        // we in cycle 6, regs in cycle 7
    endtask

    // wait for request, answer with start, check all three bytes
    task automatic collect_packet(input logic [5:0] seq, input logic [9:0] pl);
        int waited;
        waited = 0;
        while (!status_rq_o && (waited < rq_wait_c)) begin
            @(negedge pclk);
            waited++;
        end
        if (!status_rq_o) begin
            n_errors++;
            $display("status request did not arrive within %0d cycles", rq_wait_c);
        end else begin
            check_value("status_ad_o byte 0", 32'(status_ad_o), 32'h21);
            status_start_i = 1'b1;
            @(negedge pclk);
            status_start_i = 1'b0;
            check_value("status_ad_o byte 1", 32'(status_ad_o), 32'({seq, pl[1:0]}));
            check_value("status_rq_o", 32'(status_rq_o), 32'h0);  // falls after start
            @(negedge pclk);
            check_value("status_ad_o byte 2", 32'(status_ad_o), 32'(pl[9:2]));
            @(negedge pclk);
            check_value("status_ad_o", 32'(status_ad_o), 32'h0);  // idle again
        end
    endtask

    task automatic expect_no_request(input int cycles);
        repeat (cycles) begin
            @(negedge pclk);
            check_value("status_rq_o", 32'(status_rq_o), 32'h0);
            check_value("status_ad_o", 32'(status_ad_o), 32'h0);
        end
    endtask

    initial begin
        int         waited;
        logic [3:0] new_di;
        pclk                      = 1'b0;
        async_prst_with_sens_mrst = 1'b1;
        prst_i                    = 1'b0;
        cmd_ad_i                  = 8'h00;
        cmd_stb_i                 = 1'b0;
        status_start_i            = 1'b0;
        dvalid_i                  = 1'b0;
        perr_i                    = 1'b0;
        gp_di_i                   = 4'h0;
        senspgm_i                 = 1'b1;    // board present
        n_checks                  = 0;
        n_errors                  = 0;
        seed                      = 32'h394d_479e;
        exp_st = '{mrst: 1'b0, pll: 1'b0, prsts: 1'b1, perr: 1'b0, hact: 1'b0};
        repeat (2) @(negedge pclk);          // two rising edges in reset
        async_prst_with_sens_mrst = 1'b0;

        // values after reset
        check_value("sns_mrst_o", 32'(sns_mrst_o), 32'h0);
        check_value("gp_oe_o", 32'(gp_oe_o), 32'h0);
        check_value("gp_do_o", 32'(gp_do_o), 32'h0);
        check_value("status_rq_o", 32'(status_rq_o), 32'h0);
        check_value("status_ad_o", 32'(status_ad_o), 32'h0);
        repeat (4) begin
            @(negedge pclk);
            check_value("prsts_o", 32'(prsts_o), 32'h1);  // sensor still in reset
        end

        // all enables set, gp3..gp0 = trigger, high, low, float
        send_cmd(ctrl_addr_c, ctrl_word(1'b1, 1'b1, 1'b1, 1'b0, 4'hf, 8'b11_10_01_00));
        exp_st.mrst = 1'b1;
        check_value("sns_mrst_o", 32'(sns_mrst_o), 32'h1);
        check_value("gp_oe_o", 32'(gp_oe_o), 32'he);
        check_value("gp_do_o", 32'(gp_do_o), 32'hc);
        waited = 0;
        while (prsts_o && (waited < 3)) begin
            @(negedge pclk);
            waited++;
        end
        check_value("prsts_o", 32'(prsts_o), 32'h0);
        exp_st.prsts = 1'b0;

        // only gp3 enabled, to float, other fields carry ignored values
        send_cmd(ctrl_addr_c, ctrl_word(1'b0, 1'b0, 1'b0, 1'b1, 4'b1000, 8'b00_01_11_10));
        check_value("sns_mrst_o", 32'(sns_mrst_o), 32'h1);
        check_value("gp_oe_o", 32'(gp_oe_o), 32'h6);
        check_value("gp_do_o", 32'(gp_do_o), 32'h4);
        repeat (3) @(negedge pclk);
        check_value("prsts_o", 32'(prsts_o), 32'h0);  // pll reset untouched

        // outside the address mask
        send_cmd(far_addr_c, ctrl_word(1'b1, 1'b0, 1'b1, 1'b1, 4'hf, 8'hff));
        repeat (3) @(negedge pclk);
        check_value("sns_mrst_o", 32'(sns_mrst_o), 32'h1);
        check_value("gp_oe_o", 32'(gp_oe_o), 32'h6);
        check_value("gp_do_o", 32'(gp_do_o), 32'h4);
        check_value("prsts_o", 32'(prsts_o), 32'h0);

        // single mode, one packet only
        gp_di_i = 4'($random(seed));
        send_cmd(stat_addr_c, status_word(2'd1, 6'h2a));
        collect_packet(6'h2a, expected_payload());
        new_di = gp_di_i;
        while (new_di == gp_di_i) begin
            new_di = 4'($random(seed));
        end
        gp_di_i = new_di;                     // payload change, no request in single mode
        expect_no_request(10);

        // auto mode, mode write itself requests
        send_cmd(stat_addr_c, status_word(2'd2, 6'h15));
        collect_packet(6'h15, expected_payload());
        new_di = gp_di_i;
        while (new_di == gp_di_i) begin
            new_di = 4'($random(seed));
        end
        @(negedge pclk);
        gp_di_i = new_di;                     // payload change
        collect_packet(6'h15, expected_payload());

        @(negedge pclk);
        perr_i = 1'b1;
        @(negedge pclk);
        perr_i = 1'b0;
        exp_st.perr = 1'b1;                   // bit 5
        collect_packet(6'h15, expected_payload());

        @(negedge pclk);
        dvalid_i = 1'b1;                      // rising edge
        repeat (2) @(negedge pclk);
        dvalid_i = 1'b0;
        exp_st.hact = 1'b1;                   // bit 4
        collect_packet(6'h15, expected_payload());

        // control write with nothing enabled, flags clear
        send_cmd(ctrl_addr_c, ctrl_word(1'b0, 1'b0, 1'b0, 1'b0, 4'h0, 8'h00));
        exp_st.perr = 1'b0;
        exp_st.hact = 1'b0;
        collect_packet(6'h15, expected_payload());
        expect_no_request(5);

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // longest path through the tests is well below this
    initial begin
        repeat (watchdog_cyc_c) @(posedge pclk);
        $display("run did not finish within %0d cycles, checks %0d, errors %0d",
                 watchdog_cyc_c, n_checks, n_errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- files.f
sens_io_pkg.sv
cmd_deser.sv
sens_ctrl_regs.sv
sens_io_monitor.sv
status_generate.sv
sens_io_top.sv
tb_sens_io.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sensor i/o testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sens_io -f files.f -o sim_tb_sens_io

./obj_dir/sim_tb_sens_io > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0
